// ==== tb.f ====
+incdir+hw
hw/controlPkg.sv
hw/instrDecoder.sv
hw/stepSequencer.sv
hw/controlWordGen.sv
hw/controlUnit.sv
test/controlUnit_checker.sv
test/controlUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module controlUnitTb \
    -f tb.f \
    -o controlUnitSim

./obj_dir/controlUnitSim +verilator+error+limit+100 > sim.log
cat sim.log

if grep -q "^>>> PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== test/controlUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_consts.svh"

module controlUnitTb;

    typedef struct packed {
        controlPkg::instrWord_t   instr;
        controlPkg::flags_t       flags;
        logic [1:0]               cycles;
        controlPkg::aluCtrl_t     alu;
        controlPkg::regFileCtrl_t rfFirst;
        controlPkg::regFileCtrl_t rfLast;
        controlPkg::dMemCtrl_t    dmFirst;
        controlPkg::dMemCtrl_t    dmLast;
        controlPkg::fetchCtrl_t   feFirst;
        controlPkg::fetchCtrl_t   feLast;
    } vector_t;

    logic                     clk = 1'b0;
    logic                     reset;
    controlPkg::instrWord_t   instr;
    controlPkg::flags_t       flags;
    controlPkg::controlWord_t ctrl;

    vector_t vectors[$];
    int      errors = 0;
    int      totalCycles = 0;
    integer  seed = 32'h998;
    logic    tableReady = 1'b0;

    controlUnit dut (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    always #2 clk = ~clk;

    task automatic compareField(int idx, string field, logic [7:0] got, logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: vector %0d %s is %0h, expected %0h",
                     $time, idx, field, got, exp);
        end
    endtask

    task automatic checkRegFile(int idx, controlPkg::regFileCtrl_t got,
                                controlPkg::regFileCtrl_t exp);
        compareField(idx, "regFile.src", 8'(got.src), 8'(exp.src));
        compareField(idx, "regFile.outBSelect", 8'(got.outBSelect), 8'(exp.outBSelect));
        compareField(idx, "regFile.writeEnable", 8'(got.writeEnable), 8'(exp.writeEnable));
        compareField(idx, "regFile.incPair", 8'(got.incPair), 8'(exp.incPair));
        compareField(idx, "regFile.decPair", 8'(got.decPair), 8'(exp.decPair));
    endtask

    task automatic checkAlu(int idx, controlPkg::aluCtrl_t got, controlPkg::aluCtrl_t exp);
        compareField(idx, "alu.srcASelect", 8'(got.srcASelect), 8'(exp.srcASelect));
        compareField(idx, "alu.srcBSelect", 8'(got.srcBSelect), 8'(exp.srcBSelect));
        compareField(idx, "alu.mode", 8'(got.mode), 8'(exp.mode));
    endtask

    task automatic checkDMem(int idx, controlPkg::dMemCtrl_t got, controlPkg::dMemCtrl_t exp);
        compareField(idx, "dMem.dataSelect", 8'(got.dataSelect), 8'(exp.dataSelect));
        compareField(idx, "dMem.addressSelect", 8'(got.addressSelect), 8'(exp.addressSelect));
        compareField(idx, "dMem.writeEn", 8'(got.writeEn), 8'(exp.writeEn));
        compareField(idx, "dMem.readEn", 8'(got.readEn), 8'(exp.readEn));
    endtask

    task automatic checkFetch(int idx, controlPkg::fetchCtrl_t got,
                              controlPkg::fetchCtrl_t exp);
        compareField(idx, "fetch.addrSelect", 8'(got.addrSelect), 8'(exp.addrSelect));
        compareField(idx, "fetch.readEnable", 8'(got.readEnable), 8'(exp.readEnable));
        compareField(idx, "fetch.pcWriteEn", 8'(got.pcWriteEn), 8'(exp.pcWriteEn));
        compareField(idx, "fetch.flagEnable", 8'(got.flagEnable), 8'(exp.flagEnable));
    endtask

    function automatic logic condTaken(logic [2:0] cond, controlPkg::flags_t f);
        case (cond)
            `COND_CARRY:    return f.carry;
            `COND_NO_CARRY: return ~f.carry;
            `COND_ZERO:     return f.zero;
            `COND_NOT_ZERO: return ~f.zero;
            `COND_NEG:      return f.negative;
            `COND_NOT_NEG:  return ~f.negative;
            default:        return 1'b1;
        endcase
    endfunction

    // NOP word fetches the next word and nothing else
    function automatic vector_t baseVector(controlPkg::instrWord_t word, logic [3:0] regB);
        vector_t v;
        v = '0;
        v.instr = word;
        v.cycles = 2'd1;
        v.alu.srcASelect = `ALU_A_REG;
        v.alu.srcBSelect = `ALU_B_REG;
        v.alu.mode = `ALU_PASS_B;
        v.rfFirst.src = `RF_SRC_ALU;
        v.rfFirst.outBSelect = regB;
        v.dmFirst.dataSelect = `DMEM_DATA_ALU;
        v.dmFirst.addressSelect = `DMEM_ADDR_PAIR;
        v.feFirst.addrSelect = `FETCH_PC;
        v.feFirst.readEnable = 1'b1;
        v.feFirst.pcWriteEn = 1'b1;
        v.rfLast = v.rfFirst;
        v.dmLast = v.dmFirst;
        v.feLast = v.feFirst;
        return v;
    endfunction

    function automatic void addVector(vector_t v);
        vectors.push_back(v);
        totalCycles += int'(v.cycles);
    endfunction

    function automatic void addAluImm(logic [3:0] dest, logic [2:0] mode, logic [7:0] imm);
        vector_t v;
        v = baseVector({dest, imm, mode, 1'b1}, dest);
        v.alu.srcBSelect = `ALU_B_IMM;
        v.alu.mode = {1'b0, mode};
        v.rfFirst.writeEnable = 1'b1;
        v.feFirst.flagEnable = 1'b1;
        addVector(v);
    endfunction

    function automatic void addAluReg(logic [3:0] dest, logic [3:0] src, logic [4:0] op);
        vector_t v;
        v = baseVector({dest, src, op, `FMT_REG}, src);
        v.alu.mode = op[3:0];
        v.rfFirst.writeEnable = 1'b1;
        v.feFirst.flagEnable = 1'b1;
        addVector(v);
    endfunction

    function automatic void addPort(logic isIn, logic [3:0] dest);
        vector_t v;
        v = baseVector({dest, 4'h0, 5'h00, isIn ? `FMT_IN : `FMT_OUT}, dest);
        v.dmFirst.addressSelect = `DMEM_ADDR_PORT;
        v.dmFirst.readEn = 1'b1;
        if (isIn) begin
            v.cycles = 2'd2;   // port data lands in the second cycle
            v.dmLast = v.dmFirst;
            v.rfLast.writeEnable = 1'b1;
            v.feFirst.readEnable = 1'b0;
            v.feFirst.pcWriteEn = 1'b0;
        end else begin
            v.dmFirst.writeEn = 1'b1;
        end
        addVector(v);
    endfunction

    // mode 0 keeps the pair, 1 increments, 2 decrements
    function automatic void addPair(logic isLoad, logic [2:0] pair, logic [1:0] mode);
        logic [4:0] op;
        vector_t    v;
        op = (isLoad ? `OP_LOAD_FIRST : `OP_STORE_FIRST) + {3'b000, mode};
        v = baseVector({4'h0, pair, 1'b0, op, `FMT_REG}, {pair, 1'b0});
        v.alu.mode = `ALU_PASS_A;
        if (isLoad) begin
            v.cycles = 2'd2;
            v.dmFirst.readEn = 1'b1;
            v.dmLast.readEn = 1'b1;
            v.feFirst.readEnable = 1'b0;
            v.feFirst.pcWriteEn = 1'b0;
            v.rfLast.writeEnable = 1'b1;
            v.rfLast.incPair = (mode == 2'd1);
            v.rfLast.decPair = (mode == 2'd2);
        end else begin
            v.dmFirst.writeEn = 1'b1;
            v.rfFirst.incPair = (mode == 2'd1);
            v.rfFirst.decPair = (mode == 2'd2);
        end
        addVector(v);
    endfunction

    function automatic void addBranch(logic [4:0] op, logic [2:0] cond, controlPkg::flags_t f);
        logic [3:0] regB;
        vector_t    v;
        regB = (op == `OP_JMP) ? {cond, 1'b0} : `SP_LOW_REG;
        v = baseVector({cond, 1'b0, 4'h0, op, `FMT_REG}, regB);
        v.flags = f;
        if (!condTaken(cond, f)) begin
            if (op != `OP_RET) begin
                v.feFirst.addrSelect = `FETCH_PC_PLUS_ONE;   // step over address word
            end
        end else if (op == `OP_JMP) begin
            v.cycles = 2'd2;
            v.feLast.addrSelect = `FETCH_IMEM_OUT;
        end else if (op == `OP_CALL) begin
            v.cycles = 2'd2;   // low byte push, then high byte push
            v.rfFirst.decPair = 1'b1;
            v.rfLast.decPair = 1'b1;
            v.dmFirst.dataSelect = `DMEM_DATA_PC_LOW;
            v.dmFirst.writeEn = 1'b1;
            v.dmLast.dataSelect = `DMEM_DATA_PC_HIGH;
            v.dmLast.writeEn = 1'b1;
            v.feFirst.pcWriteEn = 1'b0;
            v.feLast.addrSelect = `FETCH_IMEM_OUT;
        end else begin
            v.cycles = 2'd2;   // pop over two cycles
            v.rfFirst.incPair = 1'b1;
            v.rfLast.incPair = 1'b1;
            v.dmFirst.readEn = 1'b1;
            v.dmLast.readEn = 1'b1;
            v.feFirst.addrSelect = `FETCH_IMEM_OUT;
            v.feFirst.readEnable = 1'b0;
            v.feFirst.pcWriteEn = 1'b0;
            v.feLast.addrSelect = `FETCH_IMEM_OUT;
        end
        addVector(v);
    endfunction

    function automatic void buildTable();
        logic [31:0]        r;
        controlPkg::flags_t f;
        controlPkg::flags_t fInv;
        vector_t            v;
        int                 i;
        addVector(baseVector('0, 4'h0));   // NOP straight after reset
        addAluImm(4'h3, 3'd2, 8'h5a);
        addAluReg(4'h1, 4'h7, 5'd9);
        addPort(1'b1, 4'h4);
        addPort(1'b0, 4'h6);
        for (i = 0; i < 3; i++) begin
            addPair(1'b1, 3'(i + 1), 2'(i));
            addPair(1'b0, 3'(i + 4), 2'(i));
        end
        v = baseVector({8'h00, `OP_HLT, `FMT_REG}, 4'h0);
        v.cycles = 2'd3;   // held three cycles
        v.feFirst.readEnable = 1'b0;
        v.feFirst.pcWriteEn = 1'b0;
        v.feLast = v.feFirst;
        addVector(v);
        // every condition code with a random flag set and its inverse
        for (i = 0; i < 8; i++) begin
            r = $random(seed);
            f = controlPkg::flags_t'(r[2:0]);
            fInv = controlPkg::flags_t'(~r[2:0]);
            addBranch(`OP_JMP, 3'(i), f);
            addBranch(`OP_JMP, 3'(i), fInv);
            addBranch(`OP_CALL, 3'(i), f);
            addBranch(`OP_CALL, 3'(i), fInv);
            addBranch(`OP_RET, 3'(i), f);
            addBranch(`OP_RET, 3'(i), fInv);
        end
        for (i = 0; i < 12; i++) begin
            r = $random(seed);
            addAluImm(r[3:0], (r[6:4] == 3'b111) ? 3'b000 : r[6:4], r[15:8]);
            addAluReg(r[19:16], r[23:20], 5'(32'd1 + (r % 32'd12)));
        end
        addVector(baseVector('0, 4'h0));
    endfunction

    initial begin
        int idx;
        int c;
        int assertFails;
        reset = 1'b1;
        instr = '0;
        flags = '0;
        buildTable();
        tableReady = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (idx = 0; idx < vectors.size(); idx++) begin
            @(posedge clk);
            instr <= vectors[idx].instr;
            flags <= vectors[idx].flags;
            for (c = 0; c < int'(vectors[idx].cycles); c++) begin
                if (c > 0) begin
                    @(posedge clk);
                end
                @(negedge clk);   // control word settled mid cycle
                checkAlu(idx, ctrl.alu, vectors[idx].alu);
                if (c == 0) begin
                    checkRegFile(idx, ctrl.regFile, vectors[idx].rfFirst);
                    checkDMem(idx, ctrl.dMem, vectors[idx].dmFirst);
                    checkFetch(idx, ctrl.fetch, vectors[idx].feFirst);
                end else begin
                    checkRegFile(idx, ctrl.regFile, vectors[idx].rfLast);
                    checkDMem(idx, ctrl.dMem, vectors[idx].dmLast);
                    checkFetch(idx, ctrl.fetch, vectors[idx].feLast);
                end
            end
        end
        assertFails = int'(dut.invariants.failures);
        $display("vectors %0d, cycles %0d, compare errors %0d, assertion failures %0d",
                 vectors.size(), totalCycles, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog sized once the table is known
    initial begin
        wait (tableReady);
        #((totalCycles + 20) * 4);
        $display("timeout: stimulus table not finished after %0d cycles", totalCycles + 20);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/controlUnit_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnitChecker (
    input logic                      clk,
    input logic                      reset,
    input controlPkg::step_t         step,
    input controlPkg::decodedInstr_t decoded,
    input controlPkg::controlWord_t  ctrl
);

    int unsigned failures = 0;   // assertion failures so far

    pairExclusive: assert property (@(posedge clk)
        !(ctrl.regFile.incPair && ctrl.regFile.decPair))
        else begin
            failures++;
            $error("incPair and decPair are both high");
        end

    resetStep: assert property (@(posedge clk)
        reset |=> (step == controlPkg::stepExec))
        else begin
            failures++;
            $error("step is not stepExec after reset");
        end

    // second steps never chain
    stepReturns: assert property (@(posedge clk) disable iff (reset)
        (step != controlPkg::stepExec) |=> (step == controlPkg::stepExec))
        else begin
            failures++;
            $error("second step not followed by stepExec");
        end

    haltHolds: assert property (@(posedge clk)
        (decoded.instrClass == controlPkg::clsHalt) |-> !ctrl.fetch.pcWriteEn)
        else begin
            failures++;
            $error("pcWriteEn high during HLT");
        end

endmodule

bind controlUnit controlUnitChecker invariants (
    .clk     (clk),
    .reset   (reset),
    .step    (step),
    .decoded (decoded),
    .ctrl    (ctrl)
);

`default_nettype wire

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  logic                     clk,
    input  logic                     reset,
    input  controlPkg::instrWord_t   instr,
    input  controlPkg::flags_t       flags,
    output controlPkg::controlWord_t ctrl
);

    controlPkg::decodedInstr_t decoded;
    controlPkg::step_t         step;

    instrDecoder decoder (
        .instr   (instr),
        .flags   (flags),
        .decoded (decoded)
    );

    // step register, counts the second cycle of long instructions
    stepSequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .instrClass (decoded.instrClass),
        .step       (step)
    );

    controlWordGen generator (
        .decoded (decoded),
        .step    (step),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

// ==== hw/controlWordGen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_consts.svh"

module controlWordGen (
    input  controlPkg::decodedInstr_t decoded,
    input  controlPkg::step_t         step,
    output controlPkg::controlWord_t  ctrl
);

    logic finalStep;   // second cycle of a two-step IN, load or RET

    assign finalStep = (step == controlPkg::stepWait);

    always_comb begin
        // NOP word, fetch next and nothing else
        ctrl.regFile.src          = `RF_SRC_ALU;
        ctrl.regFile.outBSelect   = decoded.regBSelect;
        ctrl.regFile.writeEnable  = 1'b0;
        ctrl.regFile.incPair      = 1'b0;
        ctrl.regFile.decPair      = 1'b0;
        ctrl.alu.srcASelect       = `ALU_A_REG;
        ctrl.alu.srcBSelect       = `ALU_B_REG;
        ctrl.alu.mode             = decoded.aluMode;
        ctrl.dMem.dataSelect      = `DMEM_DATA_ALU;
        ctrl.dMem.addressSelect   = `DMEM_ADDR_PAIR;
        ctrl.dMem.writeEn         = 1'b0;
        ctrl.dMem.readEn          = 1'b0;
        ctrl.fetch.addrSelect     = `FETCH_PC;
        ctrl.fetch.readEnable     = 1'b1;
        ctrl.fetch.pcWriteEn      = 1'b1;
        ctrl.fetch.flagEnable     = 1'b0;

        case (step)
            controlPkg::stepJumpLoad: begin
                ctrl.fetch.addrSelect = `FETCH_IMEM_OUT;   // target word is on iMem output
            end
            controlPkg::stepCallHigh: begin
                ctrl.regFile.outBSelect = `SP_LOW_REG;
                ctrl.regFile.decPair    = 1'b1;
                ctrl.dMem.dataSelect    = `DMEM_DATA_PC_HIGH;
                ctrl.dMem.writeEn       = 1'b1;
                ctrl.fetch.addrSelect   = `FETCH_IMEM_OUT;
            end
            default: begin
                case (decoded.instrClass)
                    controlPkg::clsAluImm: begin
                        ctrl.regFile.writeEnable = 1'b1;
                        ctrl.alu.srcBSelect      = `ALU_B_IMM;
                        ctrl.fetch.flagEnable    = 1'b1;
                    end
                    controlPkg::clsAluReg: begin
                        ctrl.regFile.writeEnable = 1'b1;
                        ctrl.fetch.flagEnable    = 1'b1;
                    end
                    controlPkg::clsIn: begin
                        ctrl.dMem.addressSelect  = `DMEM_ADDR_PORT;
                        ctrl.dMem.readEn         = 1'b1;
                        ctrl.regFile.writeEnable = finalStep;   // port data arrives late
                        ctrl.fetch.readEnable    = finalStep;
                        ctrl.fetch.pcWriteEn     = finalStep;
                    end
                    controlPkg::clsOut: begin
                        ctrl.dMem.addressSelect = `DMEM_ADDR_PORT;
                        ctrl.dMem.writeEn       = 1'b1;
                        ctrl.dMem.readEn        = 1'b1;
                    end
                    controlPkg::clsStorePair: begin
                        ctrl.dMem.writeEn       = 1'b1;
                        ctrl.regFile.incPair    = (decoded.pairMode == controlPkg::pairInc);
                        ctrl.regFile.decPair    = (decoded.pairMode == controlPkg::pairDec);
                    end
                    controlPkg::clsLoadPair: begin
                        ctrl.dMem.readEn         = 1'b1;
                        ctrl.regFile.writeEnable = finalStep;
                        ctrl.fetch.readEnable    = finalStep;
                        ctrl.fetch.pcWriteEn     = finalStep;
                        // pair moves once, after the read address is used
                        ctrl.regFile.incPair = finalStep
                            && (decoded.pairMode == controlPkg::pairInc);
                        ctrl.regFile.decPair = finalStep
                            && (decoded.pairMode == controlPkg::pairDec);
                    end
                    controlPkg::clsJumpTaken: begin
                        ctrl.fetch.addrSelect = `FETCH_PC;   // read the address word
                    end
                    controlPkg::clsSkipWord: begin
                        ctrl.fetch.addrSelect = `FETCH_PC_PLUS_ONE;   // skip address word
                    end
                    controlPkg::clsCallTaken: begin
                        ctrl.regFile.decPair  = 1'b1;   // push low byte
                        ctrl.dMem.dataSelect  = `DMEM_DATA_PC_LOW;
                        ctrl.dMem.writeEn     = 1'b1;
                        ctrl.fetch.pcWriteEn  = 1'b0;   // high byte still to push
                    end
                    controlPkg::clsRetTaken: begin
                        ctrl.regFile.incPair  = 1'b1;   // pop, one byte per step
                        ctrl.dMem.readEn      = 1'b1;
                        ctrl.fetch.addrSelect = `FETCH_IMEM_OUT;
                        ctrl.fetch.readEnable = finalStep;
                        ctrl.fetch.pcWriteEn  = finalStep;
                    end
                    controlPkg::clsHalt: begin
                        ctrl.fetch.readEnable = 1'b0;   // stays here while word is held
                        ctrl.fetch.pcWriteEn  = 1'b0;
                    end
                    default: begin
                        ctrl.fetch.addrSelect = `FETCH_PC;
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/stepSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module stepSequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  controlPkg::instrClass_t instrClass,
    output controlPkg::step_t       step
);

    controlPkg::step_t nextStep;

    // only the first step looks at the class, the word may change after it
    always_comb begin
        nextStep = controlPkg::stepExec;
        if (step == controlPkg::stepExec) begin
            case (instrClass)
                controlPkg::clsIn,
                controlPkg::clsLoadPair,
                controlPkg::clsRetTaken: begin
                    nextStep = controlPkg::stepWait;   // memory data next cycle
                end
                controlPkg::clsJumpTaken: begin
                    nextStep = controlPkg::stepJumpLoad;
                end
                controlPkg::clsCallTaken: begin
                    nextStep = controlPkg::stepCallHigh;
                end
                default: begin
                    nextStep = controlPkg::stepExec;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= controlPkg::stepExec;
        end else begin
            step <= nextStep;
        end
    end

endmodule

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "control_consts.svh"

module instrDecoder (
    input  controlPkg::instrWord_t    instr,
    input  controlPkg::flags_t        flags,
    output controlPkg::decodedInstr_t decoded
);

    logic [`OP_MSB-`OP_LSB:0]            opcode;
    logic [`FMT_MSB-`FMT_LSB:0]          fmt;
    logic [`COND_MSB-`COND_LSB:0]        cond;
    logic [`IMM_MODE_MSB-`IMM_MODE_LSB:0] immMode;
    logic [`REG_SEL_WIDTH-1:0]           destReg;
    logic [`REG_SEL_WIDTH-1:0]           srcReg;
    logic [`REG_SEL_WIDTH-1:0]           pairReg;
    logic [`OP_MSB-`OP_LSB:0]            storeOffset;
    logic [`OP_MSB-`OP_LSB:0]            loadOffset;
    logic                                isImm;
    logic                                condMet;

    assign opcode  = instr[`OP_MSB:`OP_LSB];
    assign fmt     = instr[`FMT_MSB:`FMT_LSB];
    assign cond    = instr[`COND_MSB:`COND_LSB];
    assign immMode = instr[`IMM_MODE_MSB:`IMM_MODE_LSB];
    assign destReg = instr[`DEST_MSB:`DEST_LSB];
    assign srcReg  = instr[`SRC_MSB:`SRC_LSB];
    assign pairReg = {instr[`PAIR_MSB:`PAIR_LSB], 1'b0};   // low register of the pair

    assign storeOffset = opcode - `OP_STORE_FIRST;   // keep, inc, dec in opcode order
    assign loadOffset  = opcode - `OP_LOAD_FIRST;

    assign isImm = instr[`IMM_FLAG_BIT] && (immMode != `IMM_MODE_NONE);

    always_comb begin
        case (cond)
            `COND_CARRY:    condMet = flags.carry;
            `COND_NO_CARRY: condMet = ~flags.carry;
            `COND_ZERO:     condMet = flags.zero;
            `COND_NOT_ZERO: condMet = ~flags.zero;
            `COND_NEG:      condMet = flags.negative;
            `COND_NOT_NEG:  condMet = ~flags.negative;
            default:        condMet = 1'b1;   // unconditional
        endcase
    end

    always_comb begin
        decoded.instrClass = controlPkg::clsNop;
        decoded.pairMode   = controlPkg::pairKeep;
        decoded.aluMode    = `ALU_PASS_B;
        decoded.regBSelect = destReg;

        if (isImm) begin
            decoded.instrClass = controlPkg::clsAluImm;
            decoded.aluMode    = {1'b0, immMode};
        end else if (fmt == `FMT_IN) begin
            decoded.instrClass = controlPkg::clsIn;
        end else if (fmt == `FMT_OUT) begin
            decoded.instrClass = controlPkg::clsOut;
        end else if (fmt != `FMT_REG) begin
            decoded.instrClass = controlPkg::clsNop;   // unused format
        end else if (opcode >= `OP_ALU_FIRST && opcode <= `OP_ALU_LAST) begin
            decoded.instrClass = controlPkg::clsAluReg;
            decoded.aluMode    = opcode[3:0];   // low opcode bits are the ALU mode
            decoded.regBSelect = srcReg;
        end else if (opcode >= `OP_STORE_FIRST && opcode <= `OP_STORE_LAST) begin
            decoded.instrClass = controlPkg::clsStorePair;
            decoded.pairMode   = controlPkg::pairMode_t'(storeOffset[1:0]);
            decoded.aluMode    = `ALU_PASS_A;
            decoded.regBSelect = pairReg;
        end else if (opcode >= `OP_LOAD_FIRST && opcode <= `OP_LOAD_LAST) begin
            decoded.instrClass = controlPkg::clsLoadPair;
            decoded.pairMode   = controlPkg::pairMode_t'(loadOffset[1:0]);
            decoded.aluMode    = `ALU_PASS_A;
            decoded.regBSelect = pairReg;
        end else if (opcode == `OP_JMP) begin
            decoded.instrClass = condMet ? controlPkg::clsJumpTaken
                                         : controlPkg::clsSkipWord;
        end else if (opcode == `OP_CALL) begin
            decoded.instrClass = condMet ? controlPkg::clsCallTaken
                                         : controlPkg::clsSkipWord;
            decoded.regBSelect = `SP_LOW_REG;
        end else if (opcode == `OP_RET) begin
            decoded.instrClass = condMet ? controlPkg::clsRetTaken
                                         : controlPkg::clsNop;
            decoded.regBSelect = `SP_LOW_REG;
        end else if (opcode == `OP_HLT) begin
            decoded.instrClass = controlPkg::clsHalt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/controlPkg.sv ====
`default_nettype none

`include "control_consts.svh"

package controlPkg;

    typedef logic [`INSTR_WIDTH-1:0] instrWord_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flags_t;

    typedef enum logic [3:0] {
        clsAluImm,
        clsAluReg,
        clsIn,
        clsOut,
        clsLoadPair,
        clsStorePair,
        clsJumpTaken,
        clsCallTaken,
        clsRetTaken,
        clsSkipWord,   // untaken JMP or CALL, step over the address word
        clsHalt,
        clsNop         // also an untaken RET
    } instrClass_t;

    typedef enum logic [1:0] {
        pairKeep = 2'd0,
        pairInc  = 2'd1,
        pairDec  = 2'd2
    } pairMode_t;

    typedef enum logic [1:0] {
        stepExec     = 2'd0,
        stepWait     = 2'd1,   // second cycle of IN, load and RET
        stepJumpLoad = 2'd2,
        stepCallHigh = 2'd3
    } step_t;

    typedef struct packed {
        instrClass_t               instrClass;
        pairMode_t                 pairMode;
        logic [3:0]                aluMode;
        logic [`REG_SEL_WIDTH-1:0] regBSelect;
    } decodedInstr_t;

    typedef struct packed {
        logic [1:0]                src;
        logic [`REG_SEL_WIDTH-1:0] outBSelect;
        logic                      writeEnable;
        logic                      incPair;
        logic                      decPair;
    } regFileCtrl_t;

    typedef struct packed {
        logic       srcASelect;
        logic [1:0] srcBSelect;
        logic [3:0] mode;
    } aluCtrl_t;

    typedef struct packed {
        logic [1:0] dataSelect;
        logic       addressSelect;
        logic       writeEn;
        logic       readEn;
    } dMemCtrl_t;

    typedef struct packed {
        logic [2:0] addrSelect;
        logic       readEnable;
        logic       pcWriteEn;
        logic       flagEnable;   // ALU flags are written
    } fetchCtrl_t;

    typedef struct packed {
        regFileCtrl_t regFile;
        aluCtrl_t     alu;
        dMemCtrl_t    dMem;
        fetchCtrl_t   fetch;
    } controlWord_t;

endpackage

`default_nettype wire

// ==== hw/control_consts.svh ====
`ifndef CONTROL_CONSTS_SVH
`define CONTROL_CONSTS_SVH

`define INSTR_WIDTH    16
`define DATA_WIDTH     8
`define REG_SEL_WIDTH  4

// instruction fields
`define COND_MSB       15
`define COND_LSB       13
`define DEST_MSB       15
`define DEST_LSB       12
`define SRC_MSB        11
`define SRC_LSB        8
`define PAIR_MSB       11
`define PAIR_LSB       9
`define OP_MSB         7
`define OP_LSB         3
`define FMT_MSB        2
`define FMT_LSB        0
`define IMM_FLAG_BIT   0
`define IMM_MODE_MSB   3
`define IMM_MODE_LSB   1

`define FMT_REG        3'b000
`define FMT_IN         3'b010
`define FMT_OUT        3'b100
`define IMM_MODE_NONE  3'b111   // bit 0 set but no immediate op

`define OP_ALU_FIRST   5'b00001
`define OP_ALU_LAST    5'b01100
`define OP_STORE_FIRST 5'b01101
`define OP_STORE_LAST  5'b01111
`define OP_LOAD_FIRST  5'b10000
`define OP_LOAD_LAST   5'b10010
`define OP_JMP         5'b10110
`define OP_CALL        5'b10111
`define OP_RET         5'b11000
`define OP_HLT         5'b11101

// condition codes, 000 and 111 mean always
`define COND_CARRY     3'b001
`define COND_NO_CARRY  3'b010
`define COND_ZERO      3'b011
`define COND_NOT_ZERO  3'b100
`define COND_NEG       3'b101
`define COND_NOT_NEG   3'b110

`define ALU_PASS_B     4'b0000
`define ALU_PASS_A     4'b1101

`define RF_SRC_ALU         2'b00
`define ALU_A_REG          1'b1
`define ALU_B_REG          2'b00
`define ALU_B_IMM          2'b10
`define DMEM_DATA_PC_HIGH  2'b00
`define DMEM_DATA_PC_LOW   2'b01
`define DMEM_DATA_ALU      2'b10
`define DMEM_ADDR_PAIR     1'b0
`define DMEM_ADDR_PORT     1'b1
`define FETCH_PC_PLUS_ONE  3'b000
`define FETCH_PC           3'b001
`define FETCH_IMEM_OUT     3'b011

`define SP_LOW_REG     4'd14

`endif
